// File: flist.f
+incdir+include
src/ring_pkg.sv
src/l1_pkg.sv
src/ring_stage1.sv
src/ring_stage2.sv
src/ring_stage3.sv
src/ring_node.sv
verif/ring_node_chk.sv
verif/ring_node_tb.sv

// File: include/ring_config.svh
//--------------------------------------------------------------------------
// Ring node configuration
// Sizes shared by the ring packet, the L1 tag arrays and the miss tables
//--------------------------------------------------------------------------

`ifndef RING_CONFIG_SVH
`define RING_CONFIG_SVH

// Hardware threads per core, one miss entry each
`define RING_THREADS 4

// Width of one cache line in bits
`define RING_LINE_BITS 64

// Line address width carried on the ring
`define RING_ADDR_BITS 32

// L1 geometry, same for both caches
`define RING_L1_SETS 8
`define RING_L1_WAYS 2

// Nodes on the ring, sizes dest_core
`define RING_CORES 4

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the ring node testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module ring_node_tb \
	-Mdir obj_dir -o ring_node_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ring_node_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
	exit 0
fi
exit 1

// File: src/l1_pkg.sv
//--------------------------------------------------------------------------
// L1 cache types
// Address split, way/set/thread indices and the core miss request
//--------------------------------------------------------------------------

`include "ring_config.svh"

package l1_pkg;

	typedef logic [$clog2(`RING_L1_SETS) - 1:0] set_idx_t;
	typedef logic [$clog2(`RING_L1_WAYS) - 1:0] way_idx_t;
	typedef logic [$clog2(`RING_THREADS) - 1:0] thread_idx_t;

	// Line address seen as tag over set index
	typedef struct packed
	{
		logic [`RING_ADDR_BITS - $clog2(`RING_L1_SETS) - 1:0] tag;
		set_idx_t set_idx;
	} l1_addr_t;

	// Miss or store strobe from the core
	typedef struct packed
	{
		logic valid;
		thread_idx_t thread;
		logic [`RING_ADDR_BITS - 1:0] address;
	} miss_req_t;

endpackage

// File: src/ring_node.sv
//--------------------------------------------------------------------------
// Ring node top
// Three-stage ring controller for one core: miss tracking, tag update,
// L1 fill and outgoing slot
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "ring_config.svh"

module ring_node import ring_pkg::*, l1_pkg::*;
	#(parameter int CORE_ID = 0)
	(input clk,
	input reset,

	// Ring
	input ring_packet_t packet_in,
	output ring_packet_t packet_out,

	// Core strobes
	input miss_req_t dcache_miss,
	input miss_req_t icache_miss,
	input miss_req_t dcache_store,

	// Data store victim read
	output set_idx_t dd_read_set,
	output way_idx_t dd_read_way,
	input logic [`RING_LINE_BITS - 1:0] dd_read_data,

	// L1 fills
	output logic dc_update_en,
	output way_idx_t dc_update_way,
	output set_idx_t dc_update_set,
	output logic [`RING_LINE_BITS - 1:0] dc_update_data,
	output logic ic_update_en,
	output way_idx_t ic_update_way,
	output set_idx_t ic_update_set,
	output logic [`RING_LINE_BITS - 1:0] ic_update_data,

	// Thread wake-up
	output logic dcache_wake,
	output thread_idx_t dcache_wake_entry,
	output logic icache_wake,
	output thread_idx_t icache_wake_entry);

	ring_packet_t rc1_packet;
	thread_idx_t rc1_dcache_miss_entry;
	thread_idx_t rc1_icache_miss_entry;
	ring_packet_t rc2_packet;
	logic rc2_need_writeback;
	logic [`RING_ADDR_BITS - 1:0] rc2_evicted_line_addr;
	way_idx_t rc2_fill_way;
	thread_idx_t rc2_dcache_miss_entry;
	thread_idx_t rc2_icache_miss_entry;

	ring_stage1 #(.CORE_ID(CORE_ID)) stage1(
		.clk(clk),
		.reset(reset),
		.packet_in(packet_in),
		.dcache_miss(dcache_miss),
		.icache_miss(icache_miss),
		// Wakes loop back to clear the miss table
		.rc3_dcache_wake(dcache_wake),
		.rc3_icache_wake(icache_wake),
		.rc3_dcache_wake_entry(dcache_wake_entry),
		.rc3_icache_wake_entry(icache_wake_entry),
		.rc1_packet(rc1_packet),
		.rc1_dcache_miss_entry(rc1_dcache_miss_entry),
		.rc1_icache_miss_entry(rc1_icache_miss_entry));

	ring_stage2 #(.CORE_ID(CORE_ID)) stage2(
		.clk(clk),
		.reset(reset),
		.rc1_packet(rc1_packet),
		.rc1_dcache_miss_entry(rc1_dcache_miss_entry),
		.rc1_icache_miss_entry(rc1_icache_miss_entry),
		.dcache_store(dcache_store),
		.rc2_packet(rc2_packet),
		.rc2_need_writeback(rc2_need_writeback),
		.rc2_evicted_line_addr(rc2_evicted_line_addr),
		.rc2_fill_way(rc2_fill_way),
		.rc2_dcache_miss_entry(rc2_dcache_miss_entry),
		.rc2_icache_miss_entry(rc2_icache_miss_entry),
		.dd_read_set(dd_read_set),
		.dd_read_way(dd_read_way));

	ring_stage3 #(.CORE_ID(CORE_ID)) stage3(
		.clk(clk),
		.reset(reset),
		.rc2_packet(rc2_packet),
		.rc2_need_writeback(rc2_need_writeback),
		.rc2_evicted_line_addr(rc2_evicted_line_addr),
		.rc2_fill_way(rc2_fill_way),
		.rc2_dcache_miss_entry(rc2_dcache_miss_entry),
		.rc2_icache_miss_entry(rc2_icache_miss_entry),
		.dd_read_data(dd_read_data),
		.packet_out(packet_out),
		.dc_update_en(dc_update_en),
		.dc_update_way(dc_update_way),
		.dc_update_set(dc_update_set),
		.dc_update_data(dc_update_data),
		.ic_update_en(ic_update_en),
		.ic_update_way(ic_update_way),
		.ic_update_set(ic_update_set),
		.ic_update_data(ic_update_data),
		.rc3_dcache_wake(dcache_wake),
		.rc3_dcache_wake_entry(dcache_wake_entry),
		.rc3_icache_wake(icache_wake),
		.rc3_icache_wake_entry(icache_wake_entry));
endmodule

// File: src/ring_pkg.sv
//--------------------------------------------------------------------------
// Ring bus types
// Packet layout and packet/cache type encodings for the coherence ring
//--------------------------------------------------------------------------

`include "ring_config.svh"

package ring_pkg;

	// Request kinds a node can place on the ring
	typedef enum logic
	{
		PKT_READ_MISS,
		PKT_L2_WRITEBACK
	} packet_type_t;

	// Which L1 a request or ack belongs to
	typedef enum logic
	{
		CT_ICACHE,
		CT_DCACHE
	} cache_type_t;

	// Ring node number
	typedef logic [$clog2(`RING_CORES) - 1:0] core_id_t;

	// One ring slot, valid clear means empty
	typedef struct packed
	{
		logic valid;
		packet_type_t packet_type;
		logic ack;
		core_id_t dest_core;
		cache_type_t cache_type;
		logic [`RING_ADDR_BITS - 1:0] address;
		logic [`RING_LINE_BITS - 1:0] data;
	} ring_packet_t;

endpackage

// File: src/ring_stage1.sv
//--------------------------------------------------------------------------
// Ring node stage 1
// Records L1 misses per thread, injects read requests into empty slots
// and finds the waiting thread for acks passing through
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "ring_config.svh"

module ring_stage1 import ring_pkg::*, l1_pkg::*;
	#(parameter int CORE_ID = 0)
	(input clk,
	input reset,
	input ring_packet_t packet_in,
	input miss_req_t dcache_miss,
	input miss_req_t icache_miss,
	input logic rc3_dcache_wake,
	input logic rc3_icache_wake,
	input thread_idx_t rc3_dcache_wake_entry,
	input thread_idx_t rc3_icache_wake_entry,
	output ring_packet_t rc1_packet,
	output thread_idx_t rc1_dcache_miss_entry,
	output thread_idx_t rc1_icache_miss_entry);

	localparam int NT = `RING_THREADS;
	localparam int NC = 2;

	// Both tables indexed by cache_type_t
	miss_req_t miss_in [NC];
	logic wake_in [NC];
	thread_idx_t wake_entry_in [NC];
	logic [NT - 1:0] tbl_valid [NC];
	logic [NT - 1:0] tbl_issued [NC];
	logic [`RING_ADDR_BITS - 1:0] tbl_addr [NC][NT];
	logic inject;
	logic issue;
	cache_type_t inject_cache;
	thread_idx_t inject_thread;
	thread_idx_t match_entry [NC];
	ring_packet_t packet_nxt;

	assign miss_in[CT_DCACHE] = dcache_miss;
	assign miss_in[CT_ICACHE] = icache_miss;
	assign wake_in[CT_DCACHE] = rc3_dcache_wake;
	assign wake_in[CT_ICACHE] = rc3_icache_wake;
	assign wake_entry_in[CT_DCACHE] = rc3_dcache_wake_entry;
	assign wake_entry_in[CT_ICACHE] = rc3_icache_wake_entry;

	// Pick pending entry, last write wins
	// Icache scanned first so any dcache entry overrides it
	// Threads scanned downward so the lowest index wins
	always_comb
	begin
		inject = 1'b0;
		inject_cache = CT_DCACHE;
		inject_thread = '0;
		for (int c = 0; c < NC; c++)
		begin
			for (int t = NT - 1; t >= 0; t--)
			begin
				if (tbl_valid[c][t] && !tbl_issued[c][t])
				begin
					inject = 1'b1;
					inject_cache = cache_type_t'(c);
					inject_thread = thread_idx_t'(t);
				end
			end
		end
	end

	// Only an empty slot can take a request
	assign issue = inject && !packet_in.valid;

	always_comb
	begin
		packet_nxt = packet_in;
		if (issue)
		begin
			packet_nxt = '0;
			packet_nxt.valid = 1'b1;
			packet_nxt.packet_type = PKT_READ_MISS;
			packet_nxt.dest_core = core_id_t'(CORE_ID);
			packet_nxt.cache_type = inject_cache;
			packet_nxt.address = tbl_addr[inject_cache][inject_thread];
		end
	end

	// Find thread waiting on this address
	// Only meaningful when the slot is an ack for this node
	always_comb
	begin
		for (int c = 0; c < NC; c++)
		begin
			match_entry[c] = '0;
			for (int t = NT - 1; t >= 0; t--)
			begin
				if (tbl_valid[c][t] && tbl_issued[c][t]
					&& tbl_addr[c][t] == packet_in.address)
					match_entry[c] = thread_idx_t'(t);
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int c = 0; c < NC; c++)
			begin
				tbl_valid[c] <= '0;
				tbl_issued[c] <= '0;
			end
		end
		else
		begin
			for (int c = 0; c < NC; c++)
			begin
				// Fill done, thread released
				if (wake_in[c])
					tbl_valid[c][wake_entry_in[c]] <= 1'b0;

				// New miss, waits for an empty slot
				if (miss_in[c].valid)
				begin
					tbl_valid[c][miss_in[c].thread] <= 1'b1;
					tbl_issued[c][miss_in[c].thread] <= 1'b0;
				end

				if (issue && int'(inject_cache) == c)
					tbl_issued[c][inject_thread] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int c = 0; c < NC; c++)
		begin
			if (miss_in[c].valid)
				tbl_addr[c][miss_in[c].thread] <= miss_in[c].address;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rc1_packet <= '0;
		else
			rc1_packet <= packet_nxt;
	end

	always_ff @(posedge clk)
	begin
		rc1_dcache_miss_entry <= match_entry[CT_DCACHE];
		rc1_icache_miss_entry <= match_entry[CT_ICACHE];
	end
endmodule

// File: src/ring_stage2.sv
//--------------------------------------------------------------------------
// Ring node stage 2
// L1 tag, valid, dirty and LRU state; picks the fill way for an ack,
// detects a dirty victim and reads its line from the data store
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "ring_config.svh"

module ring_stage2 import ring_pkg::*, l1_pkg::*;
	#(parameter int CORE_ID = 0)
	(input clk,
	input reset,
	input ring_packet_t rc1_packet,
	input thread_idx_t rc1_dcache_miss_entry,
	input thread_idx_t rc1_icache_miss_entry,
	input miss_req_t dcache_store,
	output ring_packet_t rc2_packet,
	output logic rc2_need_writeback,
	output logic [`RING_ADDR_BITS - 1:0] rc2_evicted_line_addr,
	output way_idx_t rc2_fill_way,
	output thread_idx_t rc2_dcache_miss_entry,
	output thread_idx_t rc2_icache_miss_entry,
	output set_idx_t dd_read_set,
	output way_idx_t dd_read_way);

	localparam int NS = `RING_L1_SETS;
	localparam int NW = `RING_L1_WAYS;
	localparam int NC = 2;
	localparam int TAG_W = `RING_ADDR_BITS - $clog2(`RING_L1_SETS);

	// Tag state indexed by cache_type_t, dirty for data cache only
	logic [TAG_W - 1:0] tag_mem [NC][NS][NW];
	logic [NW - 1:0] tag_valid [NC][NS];
	logic [NW - 1:0] dirty [NS];
	way_idx_t lru [NC][NS];
	l1_addr_t pkt_addr;
	l1_addr_t store_addr;
	l1_addr_t victim_addr;
	logic is_ack_for_me;
	way_idx_t fill_way [NC];
	way_idx_t sel_fill_way;
	logic need_writeback;

	assign pkt_addr = rc1_packet.address;
	assign store_addr = dcache_store.address;
	assign is_ack_for_me = rc1_packet.valid && rc1_packet.ack
		&& rc1_packet.dest_core == core_id_t'(CORE_ID);

	// First invalid way, else the LRU way
	always_comb
	begin
		for (int c = 0; c < NC; c++)
		begin
			fill_way[c] = lru[c][pkt_addr.set_idx];
			for (int w = NW - 1; w >= 0; w--)
			begin
				if (!tag_valid[c][pkt_addr.set_idx][w])
					fill_way[c] = way_idx_t'(w);
			end
		end
	end

	assign sel_fill_way = fill_way[rc1_packet.cache_type];

	// Dirty victim in the data cache goes back to L2
	assign need_writeback = is_ack_for_me && rc1_packet.cache_type == CT_DCACHE
		&& tag_valid[CT_DCACHE][pkt_addr.set_idx][fill_way[CT_DCACHE]]
		&& dirty[pkt_addr.set_idx][fill_way[CT_DCACHE]];
	assign victim_addr = {tag_mem[CT_DCACHE][pkt_addr.set_idx][fill_way[CT_DCACHE]],
		pkt_addr.set_idx};

	// Victim line read now, data lands while stage 3 holds the slot
	assign dd_read_set = pkt_addr.set_idx;
	assign dd_read_way = fill_way[CT_DCACHE];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NS; s++)
			begin
				dirty[s] <= '0;
				for (int c = 0; c < NC; c++)
				begin
					tag_valid[c][s] <= '0;
					lru[c][s] <= '0;
				end
			end
		end
		else
		begin
			// Store hit marks the line dirty, LRU untouched
			if (dcache_store.valid)
			begin
				for (int w = 0; w < NW; w++)
				begin
					if (tag_valid[CT_DCACHE][store_addr.set_idx][w]
						&& tag_mem[CT_DCACHE][store_addr.set_idx][w] == store_addr.tag)
						dirty[store_addr.set_idx][w] <= 1'b1;
				end
			end

			// Install new line clean, fill wins over a same-cycle store
			if (is_ack_for_me)
			begin
				tag_valid[rc1_packet.cache_type][pkt_addr.set_idx][sel_fill_way] <= 1'b1;
				lru[rc1_packet.cache_type][pkt_addr.set_idx] <= ~sel_fill_way;
				if (rc1_packet.cache_type == CT_DCACHE)
					dirty[pkt_addr.set_idx][sel_fill_way] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (is_ack_for_me)
			tag_mem[rc1_packet.cache_type][pkt_addr.set_idx][sel_fill_way] <= pkt_addr.tag;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rc2_packet <= '0;
			rc2_need_writeback <= 1'b0;
		end
		else
		begin
			rc2_packet <= rc1_packet;
			rc2_need_writeback <= need_writeback;
		end
	end

	always_ff @(posedge clk)
	begin
		rc2_evicted_line_addr <= victim_addr;
		rc2_fill_way <= sel_fill_way;
		rc2_dcache_miss_entry <= rc1_dcache_miss_entry;
		rc2_icache_miss_entry <= rc1_icache_miss_entry;
	end
endmodule

// File: src/ring_stage3.sv
//--------------------------------------------------------------------------
// Ring node stage 3
// Writes the filled line into L1, wakes the waiting thread and
// drives the outgoing ring slot
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "ring_config.svh"

module ring_stage3 import ring_pkg::*, l1_pkg::*;
	#(parameter int CORE_ID = 0)
	(input clk,
	input reset,
	input ring_packet_t rc2_packet,
	input logic rc2_need_writeback,
	input logic [`RING_ADDR_BITS - 1:0] rc2_evicted_line_addr,
	input way_idx_t rc2_fill_way,
	input thread_idx_t rc2_dcache_miss_entry,
	input thread_idx_t rc2_icache_miss_entry,
	input logic [`RING_LINE_BITS - 1:0] dd_read_data,
	output ring_packet_t packet_out,
	output logic dc_update_en,
	output way_idx_t dc_update_way,
	output set_idx_t dc_update_set,
	output logic [`RING_LINE_BITS - 1:0] dc_update_data,
	output logic ic_update_en,
	output way_idx_t ic_update_way,
	output set_idx_t ic_update_set,
	output logic [`RING_LINE_BITS - 1:0] ic_update_data,
	output logic rc3_dcache_wake,
	output thread_idx_t rc3_dcache_wake_entry,
	output logic rc3_icache_wake,
	output thread_idx_t rc3_icache_wake_entry);

	l1_addr_t line_addr;
	logic is_ack_for_me;
	ring_packet_t packet_nxt;

	assign line_addr = rc2_packet.address;
	assign is_ack_for_me = rc2_packet.valid && rc2_packet.ack
		&& rc2_packet.dest_core == core_id_t'(CORE_ID);

	// Data cache fill
	assign dc_update_en = is_ack_for_me && rc2_packet.cache_type == CT_DCACHE;
	assign dc_update_way = rc2_fill_way;
	assign dc_update_set = line_addr.set_idx;
	assign dc_update_data = rc2_packet.data;

	// Instruction cache fill
	assign ic_update_en = is_ack_for_me && rc2_packet.cache_type == CT_ICACHE;
	assign ic_update_way = rc2_fill_way;
	assign ic_update_set = line_addr.set_idx;
	assign ic_update_data = rc2_packet.data;

	// Thread wakes in the same cycle as its fill
	assign rc3_dcache_wake = dc_update_en;
	assign rc3_dcache_wake_entry = rc2_dcache_miss_entry;
	assign rc3_icache_wake = ic_update_en;
	assign rc3_icache_wake_entry = rc2_icache_miss_entry;

	// Consumed ack frees its slot unless a writeback takes it
	always_comb
	begin
		packet_nxt = '0;
		if (rc2_need_writeback)
		begin
			packet_nxt.valid = 1'b1;
			packet_nxt.packet_type = PKT_L2_WRITEBACK;
			packet_nxt.address = rc2_evicted_line_addr;
			packet_nxt.data = dd_read_data;
		end
		else if (!is_ack_for_me)
			packet_nxt = rc2_packet;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			packet_out <= '0;
		else
			packet_out <= packet_nxt;
	end
endmodule

// File: verif/ring_node_chk.sv
//--------------------------------------------------------------------------
// Ring node stage 3 checker
// Concurrent assertions on the fill, wake and outgoing slot of stage 3
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module ring_node_chk import ring_pkg::*;
	#(parameter int CORE_ID = 0)
	(input clk,
	input reset,
	input ring_packet_t packet_out,
	input logic rc2_need_writeback,
	input logic dc_update_en,
	input logic rc3_icache_wake);

	// Only a data cache fill can evict a dirty line to L2
	assert property (@(posedge clk) disable iff (reset) rc2_need_writeback |-> dc_update_en)
	else $error("Writeback requested without a data cache fill");

	// Instruction fills never evict so the woken ack leaves an empty slot
	assert property (@(posedge clk) disable iff (reset) rc3_icache_wake |=> !packet_out.valid)
	else $error("Slot of an instruction cache ack not freed");

	// Acks for this node never leave it
	assert property (@(posedge clk) disable iff (reset)
		!(packet_out.valid && packet_out.ack && packet_out.dest_core == core_id_t'(CORE_ID)))
	else $error("Ack for this node passed on to the ring");
endmodule

bind ring_stage3 ring_node_chk #(.CORE_ID(CORE_ID)) stage3_chk(
	.clk(clk),
	.reset(reset),
	.packet_out(packet_out),
	.rc2_need_writeback(rc2_need_writeback),
	.dc_update_en(dc_update_en),
	.rc3_icache_wake(rc3_icache_wake));

// File: verif/ring_node_tb.sv
//--------------------------------------------------------------------------
// Ring node testbench
// Models the ring, the L1 data store and the reference tag state, and runs
// directed tests for pass-through, miss round trips, eviction and back-pressure
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`include "ring_config.svh"

module ring_node_tb import ring_pkg::*, l1_pkg::*;
	();

	localparam int CORE_ID = 1;
	// Well above the cycles the tests need
	localparam int TIMEOUT_CYCLES = 400;

	logic clk;
	logic reset;
	ring_packet_t packet_in;
	ring_packet_t packet_out;
	miss_req_t dcache_miss;
	miss_req_t icache_miss;
	miss_req_t dcache_store;
	set_idx_t dd_read_set;
	way_idx_t dd_read_way;
	logic [`RING_LINE_BITS - 1:0] dd_read_data;
	logic dc_update_en;
	way_idx_t dc_update_way;
	set_idx_t dc_update_set;
	logic [`RING_LINE_BITS - 1:0] dc_update_data;
	logic ic_update_en;
	way_idx_t ic_update_way;
	set_idx_t ic_update_set;
	logic [`RING_LINE_BITS - 1:0] ic_update_data;
	logic dcache_wake;
	thread_idx_t dcache_wake_entry;
	logic icache_wake;
	thread_idx_t icache_wake_entry;

	int errors;
	int cycles;
	logic [31:0] lfsr;

	// Last four slots put on packet_in, index 0 newest
	ring_packet_t hist [4];

	// L1 data store model
	logic [`RING_LINE_BITS - 1:0] data_store [`RING_L1_SETS][`RING_L1_WAYS];

	// Expected tag state, first index is the cache type
	logic ref_valid [2][`RING_L1_SETS][`RING_L1_WAYS];
	l1_addr_t ref_line [2][`RING_L1_SETS][`RING_L1_WAYS];
	logic ref_dirty [`RING_L1_SETS][`RING_L1_WAYS];
	way_idx_t ref_lru [2][`RING_L1_SETS];

	ring_node #(.CORE_ID(CORE_ID)) UUT(.*);

	always #4 clk = ~clk;

	// Store reads with one cycle latency, fills land on the same edge
	always @(posedge clk)
	begin
		dd_read_data <= data_store[dd_read_set][dd_read_way];
		if (dc_update_en)
			data_store[dc_update_set][dc_update_way] <= dc_update_data;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, tests did not complete", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [63:0] random_bits(input int n);
		logic fb;
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[62:0], fb};
		end
		return value;
	endfunction

	// Any valid packet except an ack for this node
	function automatic ring_packet_t foreign_packet();
		ring_packet_t p;
		logic [63:0] tmp;
		tmp = random_bits(5);
		p.valid = 1'b1;
		p.packet_type = packet_type_t'(tmp[0]);
		p.ack = tmp[1];
		p.dest_core = tmp[3:2];
		p.cache_type = cache_type_t'(tmp[4]);
		if (p.ack && p.dest_core == core_id_t'(CORE_ID))
			p.dest_core = ~p.dest_core;
		tmp = random_bits(32);
		p.address = tmp[31:0];
		tmp = random_bits(64);
		p.data = tmp;
		return p;
	endfunction

	// First invalid way, else the LRU way
	function automatic way_idx_t pick_way(input cache_type_t ct, input set_idx_t s);
		way_idx_t way;
		logic found;
		way = ref_lru[ct][s];
		found = 1'b0;
		for (int w = 0; w < `RING_L1_WAYS; w++)
		begin
			if (!found && !ref_valid[ct][s][w])
			begin
				way = way_idx_t'(w);
				found = 1'b1;
			end
		end
		return way;
	endfunction

	task automatic model_fill(input cache_type_t ct, input l1_addr_t line, input way_idx_t way);
		ref_valid[ct][line.set_idx][way] = 1'b1;
		ref_line[ct][line.set_idx][way] = line;
		// LRU points at the other way
		ref_lru[ct][line.set_idx] = (way == 0) ? way_idx_t'(1) : way_idx_t'(0);
		if (ct == CT_DCACHE)
			ref_dirty[line.set_idx][way] = 1'b0;
	endtask

	task automatic model_store(input l1_addr_t line);
		for (int w = 0; w < `RING_L1_WAYS; w++)
		begin
			if (ref_valid[CT_DCACHE][line.set_idx][w]
				&& ref_line[CT_DCACHE][line.set_idx][w].tag == line.tag)
				ref_dirty[line.set_idx][w] = 1'b1;
		end
	endtask

	task automatic check_value(input string test, input string what,
		input logic [127:0] expected, input logic [127:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAIL %s %s: expected %h actual %h", test, what, expected, actual);
			errors++;
		end
	endtask

	// One ring slot per falling edge, core strobes last one slot
	task automatic next_slot(input ring_packet_t pkt);
		@(negedge clk);
		for (int i = 3; i > 0; i--)
			hist[i] = hist[i - 1];
		hist[0] = pkt;
		packet_in = pkt;
		dcache_miss = '0;
		icache_miss = '0;
		dcache_store = '0;
	endtask

	task automatic reset_test();
		check_value("reset", "packet_out", '0, 128'(packet_out));
		check_value("reset", "update and wake", '0,
			128'({dc_update_en, ic_update_en, dcache_wake, icache_wake}));
	endtask

	task automatic pass_through_test();
		for (int i = 0; i < 19; i++)
		begin
			// Three empty slots at the end flush the pipeline
			if (i < 16)
				next_slot(foreign_packet());
			else
				next_slot('0);
			check_value("pass_through", "packet_out", 128'(hist[3]), 128'(packet_out));
			check_value("pass_through", "update enables", '0,
				128'({dc_update_en, ic_update_en}));
		end
	endtask

	task automatic miss_round_trip(input string name, input cache_type_t ct,
		input thread_idx_t thread, input logic [`RING_ADDR_BITS - 1:0] addr);
		ring_packet_t req;
		ring_packet_t ack;
		ring_packet_t wb;
		l1_addr_t line;
		way_idx_t way;
		logic [63:0] tmp;
		logic [127:0] fill;
		logic [127:0] wake;
		logic [127:0] other;

		line = addr;
		way = pick_way(ct, line.set_idx);

		// Miss strobe rides with an empty slot
		next_slot('0);
		if (ct == CT_DCACHE)
			dcache_miss = {1'b1, thread, addr};
		else
			icache_miss = {1'b1, thread, addr};

		// Wait for the request, the cycle counter bounds this
		next_slot('0);
		while (!packet_out.valid)
			next_slot('0);

		req = '0;
		req.valid = 1'b1;
		req.packet_type = PKT_READ_MISS;
		req.dest_core = core_id_t'(CORE_ID);
		req.cache_type = ct;
		req.address = addr;
		check_value(name, "request", 128'(req), 128'(packet_out));

		// L2 answers with the line
		ack = req;
		ack.ack = 1'b1;
		tmp = random_bits(64);
		ack.data = tmp;

		// Dirty data-cache victim goes back to L2 in the ack's slot
		wb = '0;
		if (ct == CT_DCACHE && ref_valid[CT_DCACHE][line.set_idx][way]
			&& ref_dirty[line.set_idx][way])
		begin
			wb.valid = 1'b1;
			wb.packet_type = PKT_L2_WRITEBACK;
			wb.address = ref_line[CT_DCACHE][line.set_idx][way];
			wb.data = data_store[line.set_idx][way];
		end

		next_slot(ack);
		next_slot('0);
		next_slot('0);

		// Fill and wake two clocks after the ack entered
		if (ct == CT_DCACHE)
		begin
			fill = 128'({dc_update_en, dc_update_way, dc_update_set, dc_update_data});
			wake = 128'({dcache_wake, dcache_wake_entry});
			other = 128'({ic_update_en, icache_wake});
		end
		else
		begin
			fill = 128'({ic_update_en, ic_update_way, ic_update_set, ic_update_data});
			wake = 128'({icache_wake, icache_wake_entry});
			other = 128'({dc_update_en, dcache_wake});
		end
		check_value(name, "fill", 128'({1'b1, way, line.set_idx, tmp}), fill);
		check_value(name, "wake", 128'({1'b1, thread}), wake);
		check_value(name, "other cache idle", '0, other);

		next_slot('0);
		check_value(name, "slot after ack", 128'(wb), 128'(packet_out));
		model_fill(ct, line, way);
	endtask

	task automatic dirty_eviction_test();
		logic [63:0] tmp;
		logic [31:0] line_a;
		logic [31:0] line_b;
		logic [31:0] line_c;
		// Three lines in set 5
		tmp = random_bits(32);
		line_a = {tmp[31:3], 3'd5};
		tmp = random_bits(32);
		line_b = {tmp[31:3], 3'd5};
		tmp = random_bits(32);
		line_c = {tmp[31:3], 3'd5};
		miss_round_trip("dirty_eviction", CT_DCACHE, 2'd0, line_a);
		miss_round_trip("dirty_eviction", CT_DCACHE, 2'd1, line_b);
		// Store to the older line makes it the dirty LRU victim
		next_slot('0);
		dcache_store = {1'b1, 2'd0, line_a};
		model_store(line_a);
		miss_round_trip("dirty_eviction", CT_DCACHE, 2'd3, line_c);
	endtask

	task automatic back_pressure_test();
		ring_packet_t req;
		logic [63:0] tmp;
		logic [31:0] addr;
		tmp = random_bits(32);
		addr = tmp[31:0];
		req = '0;
		req.valid = 1'b1;
		req.packet_type = PKT_READ_MISS;
		req.dest_core = core_id_t'(CORE_ID);
		req.cache_type = CT_DCACHE;
		req.address = addr;

		// Full ring, the miss has to wait
		for (int i = 0; i < 8; i++)
		begin
			next_slot(foreign_packet());
			if (i == 0)
				dcache_miss = {1'b1, 2'd0, addr};
			check_value("back_pressure", "busy slot", 128'(hist[3]), 128'(packet_out));
		end

		// First empty slot takes the request
		next_slot('0);
		for (int i = 0; i < 3; i++)
		begin
			next_slot(foreign_packet());
			if (i < 2)
				check_value("back_pressure", "busy slot", 128'(hist[3]), 128'(packet_out));
			else
				check_value("back_pressure", "request", 128'(req), 128'(packet_out));
		end
	endtask

	initial
	begin
		logic [63:0] tmp;

		clk = 1'b0;
		reset = 1'b1;
		packet_in = '0;
		dcache_miss = '0;
		icache_miss = '0;
		dcache_store = '0;
		dd_read_data = '0;
		errors = 0;
		cycles = 0;
		lfsr = 32'h002531d3;
		for (int i = 0; i < 4; i++)
			hist[i] = '0;
		for (int s = 0; s < `RING_L1_SETS; s++)
		begin
			ref_dirty[s][0] = 1'b0;
			ref_dirty[s][1] = 1'b0;
			for (int c = 0; c < 2; c++)
			begin
				ref_lru[c][s] = '0;
				for (int w = 0; w < `RING_L1_WAYS; w++)
					ref_valid[c][s][w] = 1'b0;
			end
			// Fill pattern from set and way
			for (int w = 0; w < `RING_L1_WAYS; w++)
				data_store[s][w] = 64'hd5a7_0000_0000_0000 | 64'(s * `RING_L1_WAYS + w);
		end

		repeat (2) @(negedge clk);
		reset = 1'b0;

		reset_test();
		pass_through_test();
		tmp = random_bits(32);
		miss_round_trip("dcache_round_trip", CT_DCACHE, 2'd2, {tmp[31:3], 3'd2});
		tmp = random_bits(32);
		miss_round_trip("icache_round_trip", CT_ICACHE, 2'd1, tmp[31:0]);
		dirty_eviction_test();
		back_pressure_test();

		$display("Run complete, %0d errors", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end
endmodule
